//--- rtl/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
    input  rvPkg::aluOpE               op,
    input  logic [rvPkg::XLEN-1:0]     a,
    input  logic [rvPkg::XLEN-1:0]     b,
    input  logic [2:0]                 brFunct3,
    output logic [rvPkg::XLEN-1:0]     y,
    output logic                       brTrue
);

    logic [4:0] shamt;
    logic       eq;
    logic       ltS;
    logic       ltU;

    // Shift amount from the low five bits only
    assign shamt = b[4:0];

    // Comparisons shared by SLT and the branch unit
    assign eq  = (a == b);
    assign ltS = ($signed(a) < $signed(b));
    assign ltU = (a < b);

    always_comb
    begin
        case (op)
            rvPkg::ALU_ADD:
                y = a + b;
            rvPkg::ALU_SUB:
                y = a - b;
            rvPkg::ALU_SLL:
                y = a << shamt;
            rvPkg::ALU_SLT:
                y = {{(rvPkg::XLEN-1){1'b0}}, ltS};
            rvPkg::ALU_SLTU:
                y = {{(rvPkg::XLEN-1){1'b0}}, ltU};
            rvPkg::ALU_XOR:
                y = a ^ b;
            rvPkg::ALU_SRL:
                y = a >> shamt;
            // Arithmetic shift keeps the sign
            rvPkg::ALU_SRA:
                y = $unsigned($signed(a) >>> shamt);
            rvPkg::ALU_OR:
                y = a | b;
            rvPkg::ALU_AND:
                y = a & b;
            // LUI path
            rvPkg::ALU_PASSB:
                y = b;
            default:
                y = a + b;
        endcase
    end

    // Branch condition by funct3
    always_comb
    begin
        case (brFunct3)
            3'b000:  brTrue = eq;
            3'b001:  brTrue = !eq;
            3'b100:  brTrue = ltS;
            3'b101:  brTrue = !ltS;
            3'b110:  brTrue = ltU;
            3'b111:  brTrue = !ltU;
            default: brTrue = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/decodeExecTop.sv
`timescale 1ns/10ps
`default_nettype none

module decodeExecTop #(
    parameter logic [rvPkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instrValid,
    input  logic [31:0]                instr,
    input  logic [rvPkg::XLEN-1:0]     pc,
    output rvPkg::execResT             res
);

    logic                      heldValid;
    rvPkg::instrU              heldInstr;
    logic [rvPkg::XLEN-1:0]    heldPc;
    rvPkg::ctrlT               ctrl;
    logic [rvPkg::XLEN-1:0]    imm;
    logic [rvPkg::XLEN-1:0]    rs1Data;
    logic [rvPkg::XLEN-1:0]    rs2Data;
    logic [rvPkg::XLEN-1:0]    opA;
    logic [rvPkg::XLEN-1:0]    opB;
    logic [rvPkg::XLEN-1:0]    aluY;
    logic                      brTrue;
    logic [rvPkg::XLEN-1:0]    linkPc;
    logic [rvPkg::XLEN-1:0]    target;
    rvPkg::execResT            resNext;

    instrDecode uDecode (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .heldValid  (heldValid),
        .heldInstr  (heldInstr),
        .heldPc     (heldPc),
        .ctrl       (ctrl)
    );

    immGen uImm (
        .word (heldInstr),
        .fmt  (ctrl.immFmt),
        .imm  (imm)
    );

    // Write port fed from the next result, so it lands as the next word is captured
    regFile uRegs (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (heldInstr.r.rs1),
        .rdAddrB (heldInstr.r.rs2),
        .wrEn    (resNext.regWrite),
        .wrAddr  (resNext.rd),
        .wrData  (resNext.result),
        .rdDataA (rs1Data),
        .rdDataB (rs2Data)
    );

    // Operand muxes
    assign opA = ctrl.aSrcPc ? heldPc : rs1Data;
    assign opB = ctrl.aluSrcImm ? imm : rs2Data;

    aluUnit uAlu (
        .op       (ctrl.aluOp),
        .a        (opA),
        .b        (opB),
        .brFunct3 (heldInstr.r.funct3),
        .y        (aluY),
        .brTrue   (brTrue)
    );

    assign linkPc = heldPc + 32'd4;
    // JALR base is rs1 + imm from the ALU, low bit dropped
    assign target = ctrl.isJalr ? {aluY[rvPkg::XLEN-1:1], 1'b0} : heldPc + imm;

    always_comb
    begin
        resNext           = '0;
        resNext.valid     = heldValid;
        resNext.result    = (ctrl.isJal || ctrl.isJalr) ? linkPc : aluY;
        resNext.rd        = heldInstr.r.rd;
        // Side effects only for a real instruction
        resNext.regWrite  = heldValid && ctrl.regWrite;
        resNext.memRead   = heldValid && ctrl.memRead;
        resNext.memWrite  = heldValid && ctrl.memWrite;
        resNext.memAddr   = aluY;
        resNext.storeData = rs2Data;
        resNext.memWidth  = heldInstr.r.funct3;
        resNext.redirect  = heldValid &&
                            (ctrl.isJal || ctrl.isJalr || (ctrl.isBranch && brTrue));
        resNext.target    = target;
        resNext.illegal   = heldValid && ctrl.illegal;
    end

    // Result register, target parks at the reset vector
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            res        <= '0;
            res.target <= RESET_PC;
        end
        else
        begin
            res <= resNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/immGen.sv
`timescale 1ns/10ps
`default_nettype none

module immGen (
    input  rvPkg::instrU               word,
    input  rvPkg::immFmtE              fmt,
    output logic [rvPkg::XLEN-1:0]     imm
);

    // Pieces are pulled from the matching format view
    always_comb
    begin
        case (fmt)
            rvPkg::IMM_I:
                imm = {{20{word.i.imm[11]}}, word.i.imm};
            rvPkg::IMM_S:
                imm = {{20{word.s.immHi[6]}}, word.s.immHi, word.s.immLo};
            // Branch offsets are in halfwords
            rvPkg::IMM_B:
                imm = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                       word.b.imm10_5, word.b.imm4_1, 1'b0};
            rvPkg::IMM_U:
                imm = {word.u.imm31_12, 12'b0};
            // Same halfword scaling for JAL
            rvPkg::IMM_J:
                imm = {{11{word.j.imm20}}, word.j.imm20, word.j.imm19_12,
                       word.j.imm11, word.j.imm10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instrValid,
    input  logic [31:0]                instr,
    input  logic [rvPkg::XLEN-1:0]     pc,
    output logic                       heldValid,
    output rvPkg::instrU               heldInstr,
    output logic [rvPkg::XLEN-1:0]     heldPc,
    output rvPkg::ctrlT                ctrl
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    // Maps funct3 to an ALU op, alt picks SUB or SRA
    function automatic rvPkg::aluOpE opFromF3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  opFromF3 = alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            3'b001:  opFromF3 = rvPkg::ALU_SLL;
            3'b010:  opFromF3 = rvPkg::ALU_SLT;
            3'b011:  opFromF3 = rvPkg::ALU_SLTU;
            3'b100:  opFromF3 = rvPkg::ALU_XOR;
            3'b101:  opFromF3 = alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
            3'b110:  opFromF3 = rvPkg::ALU_OR;
            default: opFromF3 = rvPkg::ALU_AND;
        endcase
    endfunction

    // Strobe follows every cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            heldValid <= 1'b0;
        else
            heldValid <= instrValid;
    end

    // Word and PC only move on a strobe
    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            heldInstr <= instr;
            heldPc    <= pc;
        end
    end

    assign funct3 = heldInstr.r.funct3;
    assign funct7 = heldInstr.r.funct7;

    always_comb
    begin
        // Defaults describe a harmless no-op
        ctrl        = '0;
        ctrl.aluOp  = rvPkg::ALU_ADD;
        ctrl.immFmt = rvPkg::IMM_NONE;

        case (heldInstr.r.opcode)
            rvPkg::OP_LUI:
            begin
                ctrl.aluOp     = rvPkg::ALU_PASSB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.immFmt    = rvPkg::IMM_U;
            end
            rvPkg::OP_AUIPC:
            begin
                ctrl.aSrcPc    = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.immFmt    = rvPkg::IMM_U;
            end
            // Link value comes from the top, not the ALU
            rvPkg::OP_JAL:
            begin
                ctrl.isJal    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.immFmt   = rvPkg::IMM_J;
            end
            // ALU forms rs1 + imm for the jump base
            rvPkg::OP_JALR:
            begin
                ctrl.isJalr    = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.immFmt    = rvPkg::IMM_I;
                ctrl.illegal   = (funct3 != 3'b000);
            end
            // Compare is rs1 against rs2, funct3 goes straight to the ALU
            rvPkg::OP_BRANCH:
            begin
                ctrl.isBranch = 1'b1;
                ctrl.immFmt   = rvPkg::IMM_B;
                ctrl.illegal  = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            // LB LH LW LBU LHU only
            rvPkg::OP_LOAD:
            begin
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immFmt    = rvPkg::IMM_I;
                ctrl.illegal   = (funct3 == 3'b011) || (funct3 == 3'b110) ||
                                 (funct3 == 3'b111);
            end
            // SB SH SW
            rvPkg::OP_STORE:
            begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immFmt    = rvPkg::IMM_S;
                ctrl.illegal   = (funct3 > 3'b010);
            end
            rvPkg::OP_OPIMM:
            begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.immFmt    = rvPkg::IMM_I;
                // Only the shifts look at funct7
                ctrl.aluOp = opFromF3(funct3, (funct3 == 3'b101) && (funct7 == 7'b0100000));
                if (funct3 == 3'b001)
                    ctrl.illegal = (funct7 != 7'b0000000);
                else if (funct3 == 3'b101)
                    ctrl.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
            rvPkg::OP_OP:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = opFromF3(funct3, funct7 == 7'b0100000);
                // Alternate funct7 exists only for SUB and SRA
                // funct7 0000001 is MUL/DIV, rejected here too
                if (funct7 == 7'b0100000)
                    ctrl.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                else
                    ctrl.illegal = (funct7 != 7'b0000000);
            end
            default:
                ctrl.illegal = 1'b1;
        endcase

        // Illegal words must leave no side effect
        if (ctrl.illegal)
        begin
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.isBranch = 1'b0;
            ctrl.isJal    = 1'b0;
            ctrl.isJalr   = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [4:0]                 rdAddrA,
    input  logic [4:0]                 rdAddrB,
    input  logic                       wrEn,
    input  logic [4:0]                 wrAddr,
    input  logic [rvPkg::XLEN-1:0]     wrData,
    output logic [rvPkg::XLEN-1:0]     rdDataA,
    output logic [rvPkg::XLEN-1:0]     rdDataB
);

    // x0 has no storage
    logic [rvPkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        // Writes to x0 vanish here
        else if (wrEn && (wrAddr != 5'd0))
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Combinational reads, x0 reads as zero
    always_comb
    begin
        if (rdAddrA == 5'd0)
            rdDataA = '0;
        else
            rdDataA = regs[rdAddrA];

        if (rdAddrB == 5'd0)
            rdDataB = '0;
        else
            rdDataB = regs[rdAddrB];
    end

endmodule

`default_nettype wire

//--- rtl/rvPkg.sv
`default_nettype none

package rvPkg;

    // Data path width
    localparam int XLEN = 32;

    // Base opcodes handled by the slice
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOpE;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } immFmtE;

    // Format views, all 32 bits, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // One instruction word, six ways to read it
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrU;

    typedef struct packed {
        aluOpE  aluOp;
        logic   aluSrcImm;
        logic   aSrcPc;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   isBranch;
        logic   isJal;
        logic   isJalr;
        immFmtE immFmt;
        logic   illegal;
    } ctrlT;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] result;
        logic [4:0]      rd;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic [XLEN-1:0] memAddr;
        logic [XLEN-1:0] storeData;
        logic [2:0]      memWidth;
        logic            redirect;
        logic [XLEN-1:0] target;
        logic            illegal;
    } execResT;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tbDecodeExec -f sim.f -o simDecodeExec \
    && ./obj_dir/simDecodeExec \
    || exit 1

//--- sim.f
rtl/rvPkg.sv
rtl/immGen.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/decodeExecTop.sv
sim/tbDecodeExec.sv

//--- sim/tbDecodeExec.sv
`timescale 1ns/10ps
`default_nettype none

module tbDecodeExec;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int NUM_RANDOM = 1000;
    // Reset, 1000 issues and about one idle slot in eight, with margin
    localparam int TIMEOUT_CYCLES = 2000;

    // One predicted result and which fields matter for it
    typedef struct {
        string          name;
        rvPkg::execResT e;
        bit             chkResult;
        bit             chkAddr;
        bit             chkStore;
        bit             chkTarget;
    } expT;

    logic           clk;
    logic           rst;
    logic           instrValid;
    logic [31:0]    instr;
    logic [31:0]    pc;
    rvPkg::execResT res;

    logic [31:0] lfsrState;
    logic [31:0] shadow [0:31];
    logic [31:0] curPc;
    logic [1:0]  validPipe = 2'b00;
    logic        expValid;
    int          cycleCount = 0;
    expT         pending [$];

    decodeExecTop #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .res        (res)
    );

    always #20 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "testbench check failed");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randField(input int width);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < width; k++)
        begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // RV32I integer ops by funct3, alt selects SUB and SRA
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic [4:0]         sh;
        sa = a;
        sh = b[4:0];
        case (f3)
            3'b000:  aluModel = alt ? a - b : a + b;
            3'b001:  aluModel = a << sh;
            3'b010:  aluModel = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  aluModel = (a < b) ? 32'd1 : 32'd0;
            3'b100:  aluModel = a ^ b;
            3'b101:
            begin
                if (alt)
                    aluModel = sa >>> sh;
                else
                    aluModel = a >> sh;
            end
            3'b110:  aluModel = a | b;
            default: aluModel = a & b;
        endcase
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  branchModel = (a == b);
            3'b001:  branchModel = (a != b);
            3'b100:  branchModel = ($signed(a) < $signed(b));
            3'b101:  branchModel = ($signed(a) >= $signed(b));
            3'b110:  branchModel = (a < b);
            default: branchModel = (a >= b);
        endcase
    endfunction

    function automatic expT blankExp(input string name, input logic [4:0] rd);
        expT ex;
        ex.name      = name;
        ex.e         = '0;
        ex.e.valid   = 1'b1;
        ex.e.rd      = rd;
        ex.chkResult = 1'b0;
        ex.chkAddr   = 1'b0;
        ex.chkStore  = 1'b0;
        ex.chkTarget = 1'b0;
        return ex;
    endfunction

    task automatic issue(input logic [31:0] word, input expT ex);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= word;
        pc         <= curPc;
        pending.push_back(ex);
        curPc = curPc + 32'd4;
    endtask

    task automatic idle();
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    // Random instruction of a random class, predicted from the shadow registers
    task automatic runRandom(input int idx);
        logic [3:0]  cls;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [12:0] off13;
        logic [20:0] off21;
        logic [19:0] up20;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] word;
        logic [6:0]  badOp;
        logic        alt;
        expT         ex;
        cls   = 4'(randField(4));
        // Only x0..x7, so dependent pairs and x0 writes come up often
        rs1   = 5'(randField(3));
        rs2   = 5'(randField(3));
        rd    = 5'(randField(3));
        f3    = 3'(randField(3));
        imm12 = 12'(randField(12));
        a     = shadow[rs1];
        b     = shadow[rs2];
        ex    = blankExp($sformatf("instr%0d", idx), rd);
        case (cls)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
            begin
                alt  = ((f3 == 3'b000) || (f3 == 3'b101)) && (randField(1) != 0);
                word = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
                ex.name        = $sformatf("op%0d", idx);
                ex.e.result    = aluModel(f3, alt, a, b);
                ex.e.regWrite  = 1'b1;
                ex.chkResult   = 1'b1;
            end
            4'd5, 4'd6, 4'd7, 4'd8:
            begin
                alt = (f3 == 3'b101) && (randField(1) != 0);
                // Shift immediates carry funct7 above shamt
                if ((f3 == 3'b001) || (f3 == 3'b101))
                    imm12 = {alt ? 7'b0100000 : 7'b0000000, imm12[4:0]};
                sImm = {{20{imm12[11]}}, imm12};
                word = {imm12, rs1, f3, rd, 7'b0010011};
                ex.name        = $sformatf("opimm%0d", idx);
                ex.e.result    = aluModel(f3, alt, a, sImm);
                ex.e.regWrite  = 1'b1;
                ex.chkResult   = 1'b1;
            end
            4'd9, 4'd10:
            begin
                up20 = 20'(randField(20));
                ex.e.regWrite  = 1'b1;
                ex.chkResult   = 1'b1;
                if (cls == 4'd9)
                begin
                    word        = {up20, rd, 7'b0110111};
                    ex.name     = $sformatf("lui%0d", idx);
                    ex.e.result = {up20, 12'b0};
                end
                else
                begin
                    word        = {up20, rd, 7'b0010111};
                    ex.name     = $sformatf("auipc%0d", idx);
                    ex.e.result = curPc + {up20, 12'b0};
                end
            end
            4'd11:
            begin
                // Keep to LB LH LW LBU LHU
                if ((f3 == 3'b011) || (f3[2:1] == 2'b11))
                    f3 = {2'b00, f3[0]};
                sImm = {{20{imm12[11]}}, imm12};
                word = {imm12, rs1, f3, rd, 7'b0000011};
                ex.name       = $sformatf("load%0d", idx);
                ex.e.memRead  = 1'b1;
                ex.e.memAddr  = a + sImm;
                ex.e.memWidth = f3;
                ex.chkAddr    = 1'b1;
            end
            4'd12:
            begin
                f3   = f3 % 3'd3;
                sImm = {{20{imm12[11]}}, imm12};
                word = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
                ex.name        = $sformatf("store%0d", idx);
                ex.e.memWrite  = 1'b1;
                ex.e.memAddr   = a + sImm;
                ex.e.memWidth  = f3;
                ex.e.storeData = b;
                ex.chkAddr     = 1'b1;
                ex.chkStore    = 1'b1;
            end
            4'd13:
            begin
                // funct3 010 and 011 are not branches
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;
                off13 = {imm12, 1'b0};
                word  = {off13[12], off13[10:5], rs2, rs1, f3, off13[4:1], off13[11],
                         7'b1100011};
                ex.name        = $sformatf("branch%0d", idx);
                ex.e.redirect  = branchModel(f3, a, b);
                ex.e.target    = curPc + {{19{off13[12]}}, off13};
                ex.chkTarget   = 1'b1;
            end
            4'd14:
            begin
                ex.e.result    = curPc + 32'd4;
                ex.e.regWrite  = 1'b1;
                ex.e.redirect  = 1'b1;
                ex.chkResult   = 1'b1;
                ex.chkTarget   = 1'b1;
                if (randField(1) != 0)
                begin
                    off21 = {20'(randField(20)), 1'b0};
                    word  = {off21[20], off21[10:1], off21[11], off21[19:12], rd, 7'b1101111};
                    ex.name     = $sformatf("jal%0d", idx);
                    ex.e.target = curPc + {{11{off21[20]}}, off21};
                end
                else
                begin
                    sImm = {{20{imm12[11]}}, imm12};
                    word = {imm12, rs1, 3'b000, rd, 7'b1100111};
                    ex.name     = $sformatf("jalr%0d", idx);
                    ex.e.target = (a + sImm) & ~32'd1;
                end
            end
            default:
            begin
                case (randField(3))
                    32'd0:   badOp = 7'b0001111;
                    32'd1:   badOp = 7'b1110011;
                    32'd2:   badOp = 7'b0000000;
                    32'd3:   badOp = 7'b1111111;
                    default: badOp = 7'b0110011;
                endcase
                // Opcode OP here means an M-extension word
                if (badOp == 7'b0110011)
                    word = {7'b0000001, rs2, rs1, f3, rd, badOp};
                else
                    word = {25'(randField(25)), badOp};
                ex.name      = $sformatf("illegal%0d", idx);
                ex.e.illegal = 1'b1;
            end
        endcase
        // Sequential shadow update matches the no-forwarding write timing
        if (ex.e.regWrite && (rd != 5'd0))
            shadow[rd] = ex.e.result;
        issue(word, ex);
    endtask

    task automatic compareField(input string test, input string field,
                                input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp)
        else failRun($sformatf("Mismatch %s %s: expected %h, actual %h",
                               test, field, exp, act));
    endtask

    task automatic checkResult();
        expT ex;
        if (pending.size() == 0)
            failRun("A result appeared with no instruction outstanding");
        else
        begin
            ex = pending.pop_front();
            compareField(ex.name, "flags",
                         32'({ex.e.regWrite, ex.e.memRead, ex.e.memWrite,
                              ex.e.redirect, ex.e.illegal}),
                         32'({res.regWrite, res.memRead, res.memWrite,
                              res.redirect, res.illegal}));
            if (ex.chkResult)
            begin
                compareField(ex.name, "result", ex.e.result, res.result);
                compareField(ex.name, "rd", 32'(ex.e.rd), 32'(res.rd));
            end
            if (ex.chkAddr)
            begin
                compareField(ex.name, "memAddr", ex.e.memAddr, res.memAddr);
                compareField(ex.name, "memWidth", 32'(ex.e.memWidth), 32'(res.memWidth));
            end
            if (ex.chkStore)
                compareField(ex.name, "storeData", ex.e.storeData, res.storeData);
            if (ex.chkTarget)
                compareField(ex.name, "target", ex.e.target, res.target);
        end
    endtask

    // Outputs sampled mid-cycle, strobe expected two edges after capture
    always @(negedge clk)
    begin
        expValid  = validPipe[1];
        validPipe = {validPipe[0], instrValid};
        compareField("strobe", "valid", 32'(expValid), 32'(res.valid));
        if (res.valid)
            checkResult();
        else
            compareField("quiet", "flags", 32'd0,
                         32'({res.regWrite, res.memRead, res.memWrite,
                              res.redirect, res.illegal}));
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
            failRun($sformatf("Timeout: run still going after %0d cycles", cycleCount));
    end

    initial
    begin
        int n;
        int r;
        clk        = 1'b0;
        rst        <= 1'b1;
        instrValid <= 1'b0;
        instr      <= '0;
        pc         <= '0;
        lfsrState  = 32'h0e7760ab;
        curPc      = 32'h0000_1000;
        for (r = 0; r < 32; r++)
            shadow[r] = '0;

        repeat (15) @(posedge clk);
        // Result target sits at the reset vector while reset is held
        @(negedge clk);
        compareField("reset", "target", RESET_PC, res.target);
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (n = 0; n < NUM_RANDOM; n++)
        begin
            // Occasional bubble between issues
            if (randField(3) == 32'd0)
                idle();
            runRandom(n);
        end
        idle();

        // Drain, then a few quiet cycles for stray pulses
        while (pending.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
